//--- project.f
source/rvdec_pkg.sv
source/rvdec_ctrl.sv
source/rvdec_imm_gen.sv
source/rvdec_mem_lane.sv
source/rvdec_trap_unit.sv
source/rvdec_stage_reg.sv
source/rvdec_top.sv
verification/rvdec_sva.sv
verification/rvdec_tb.sv

//--- source/rvdec_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rvdec_ctrl (
    input  logic [rvdec_pkg::INST_W-1:0] inst,
    output rvdec_pkg::dec_ctrl_t         ctrl,
    output rvdec_pkg::imm_kind_e         imm_kind,
    output rvdec_pkg::mem_kind_e         mem_kind,
    output rvdec_pkg::sys_kind_e         sys_kind
);
    import rvdec_pkg::*;

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    always_comb begin
        ctrl     = '0;
        imm_kind = imm_none;
        mem_kind = mem_none;
        sys_kind = sys_none;
        case (opcode)
            opc_op, opc_op_32: begin
                ctrl.rs1     = rs1;
                ctrl.rs2     = rs2;
                ctrl.rd      = rd;
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = src_reg;
                ctrl.word_op = (opcode == opc_op_32);
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.alu_op = alu_add;
                    10'b0100000_000: ctrl.alu_op = alu_sub;
                    10'b0000000_001: ctrl.alu_op = alu_sll;
                    10'b0000000_010: ctrl.alu_op = alu_slt;
                    10'b0000000_011: ctrl.alu_op = alu_sltu;
                    10'b0000000_100: ctrl.alu_op = alu_xor;
                    10'b0000000_101: ctrl.alu_op = alu_srl;
                    10'b0100000_101: ctrl.alu_op = alu_sra;
                    10'b0000000_110: ctrl.alu_op = alu_or;
                    10'b0000000_111: ctrl.alu_op = alu_and;
                    10'b0000001_000: ctrl.alu_op = alu_mul;
                    10'b0000001_100: ctrl.alu_op = alu_div;
                    10'b0000001_101: ctrl.alu_op = alu_divu;
                    10'b0000001_110: ctrl.alu_op = alu_rem;
                    10'b0000001_111: ctrl.alu_op = alu_remu;
                    default:         ctrl.illegal = 1'b1; // incl. mulh variants
                endcase
                ctrl.is_mul = (funct7 == 7'b0000001) && (funct3 == 3'b000);
                ctrl.is_div = (funct7 == 7'b0000001) && funct3[2];
                // W forms have no compare or logic ops
                if (ctrl.word_op && funct7 == 7'b0000000 &&
                    !(funct3 inside {3'b000, 3'b001, 3'b101}))
                    ctrl.illegal = 1'b1;
            end
            opc_op_imm, opc_op_imm_32: begin
                ctrl.rs1     = rs1;
                ctrl.rd      = rd;
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = src_imm;
                ctrl.word_op = (opcode == opc_op_imm_32);
                imm_kind     = imm_i;
                case (funct3)
                    3'b000: ctrl.alu_op = alu_add;
                    3'b010: ctrl.alu_op = alu_slt;
                    3'b011: ctrl.alu_op = alu_sltu;
                    3'b100: ctrl.alu_op = alu_xor;
                    3'b110: ctrl.alu_op = alu_or;
                    3'b111: ctrl.alu_op = alu_and;
                    3'b001: begin
                        ctrl.alu_op  = alu_sll;
                        imm_kind     = imm_shamt;
                        ctrl.illegal = (inst[31:26] != 6'b000000);
                    end
                    default: begin // 3'b101
                        imm_kind = imm_shamt;
                        case (inst[31:26])
                            6'b000000: ctrl.alu_op = alu_srl;
                            6'b010000: ctrl.alu_op = alu_sra;
                            default:   ctrl.illegal = 1'b1;
                        endcase
                    end
                endcase
                if (ctrl.word_op && !(funct3 inside {3'b000, 3'b001, 3'b101}))
                    ctrl.illegal = 1'b1;
                if (ctrl.word_op && funct3[0] && inst[25])
                    ctrl.illegal = 1'b1; // shamt[5] reserved for W shifts
            end
            opc_load: begin
                ctrl.rs1     = rs1;
                ctrl.rd      = rd;
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = src_imm;  // address = rs1 + imm
                imm_kind     = imm_i;
                mem_kind     = mem_load;
                ctrl.illegal = (funct3 == 3'b111);
            end
            opc_store: begin
                ctrl.rs1     = rs1;
                ctrl.rs2     = rs2;
                ctrl.alu_src = src_imm;
                imm_kind     = imm_s;
                mem_kind     = mem_store;
                ctrl.illegal = funct3[2];
            end
            opc_branch: begin
                ctrl.rs1     = rs1;
                ctrl.rs2     = rs2;
                ctrl.alu_src = src_reg;
                ctrl.branch  = 1'b1;
                imm_kind     = imm_b;
                case (funct3)
                    3'b000:  ctrl.alu_op = alu_beq;
                    3'b001:  ctrl.alu_op = alu_bne;
                    3'b100:  ctrl.alu_op = alu_blt;
                    3'b101:  ctrl.alu_op = alu_bge;
                    3'b110:  ctrl.alu_op = alu_bltu;
                    3'b111:  ctrl.alu_op = alu_bgeu;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            opc_jal: begin
                ctrl.rd      = rd;
                ctrl.reg_wen = 1'b1;
                ctrl.jump    = 1'b1;
                ctrl.alu_src = src_pc_plus4;
                imm_kind     = imm_j;
            end
            opc_jalr: begin
                ctrl.rs1     = rs1;
                ctrl.rd      = rd;
                ctrl.reg_wen = 1'b1;
                ctrl.jump    = 1'b1;
                ctrl.jalr    = 1'b1;
                ctrl.alu_src = src_pc_plus4;
                imm_kind     = imm_i;
                ctrl.illegal = (funct3 != 3'b000);
            end
            opc_lui: begin
                ctrl.rd      = rd;
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = src_imm; // x0 + imm
                imm_kind     = imm_u;
            end
            opc_auipc: begin
                ctrl.rd      = rd;
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = src_imm_pc;
                imm_kind     = imm_u;
            end
            opc_system: begin
                if (funct3 == 3'b001) begin // csrrw
                    ctrl.rs1      = rs1;
                    ctrl.rd       = rd;
                    ctrl.reg_wen  = 1'b1;
                    ctrl.alu_op   = alu_csrrw;
                    ctrl.alu_src  = src_csr;
                    ctrl.csr_addr = inst[31:20];
                end else if (inst == 32'h0000_0073) begin
                    sys_kind = sys_ecall;
                end else if (inst == 32'h3020_0073) begin
                    sys_kind = sys_mret;
                end else if (inst == 32'h0010_0073) begin
                    sys_kind = sys_ebreak;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            default: ctrl.illegal = 1'b1;
        endcase
        // an unknown encoding must not write, branch or trap
        if (ctrl.illegal) begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
            imm_kind     = imm_none;
            mem_kind     = mem_none;
            sys_kind     = sys_none;
        end
    end

endmodule

`default_nettype wire

//--- source/rvdec_imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module rvdec_imm_gen #(
    parameter int XLEN_P = rvdec_pkg::XLEN
) (
    input  logic [rvdec_pkg::INST_W-1:0] inst,
    input  rvdec_pkg::imm_kind_e         imm_kind,
    output logic [XLEN_P-1:0]            imm
);
    import rvdec_pkg::*;

    logic signed [11:0] i_field;
    logic signed [11:0] s_field;
    logic signed [12:0] b_field;
    logic signed [31:0] u_field;
    logic signed [20:0] j_field;

    assign i_field = inst[31:20];
    assign s_field = {inst[31:25], inst[11:7]};
    assign b_field = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_field = {inst[31:12], 12'b0};
    assign j_field = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // signed fields sign-extend on the size cast
    always_comb begin
        case (imm_kind)
            imm_i:     imm = XLEN_P'(i_field);
            imm_s:     imm = XLEN_P'(s_field);
            imm_b:     imm = XLEN_P'(b_field);
            imm_u:     imm = XLEN_P'(u_field);
            imm_j:     imm = XLEN_P'(j_field);
            imm_shamt: imm = XLEN_P'(inst[25:20]); // zero-extended
            default:   imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/rvdec_mem_lane.sv
`timescale 1ns/1ps
`default_nettype none

module rvdec_mem_lane (
    input  logic [rvdec_pkg::INST_W-1:0] inst,
    input  rvdec_pkg::mem_kind_e         mem_kind,
    output logic [rvdec_pkg::MASK_W-1:0] wmask,
    output logic [1:0]                   load_size,
    output logic                         load_signed
);
    import rvdec_pkg::*;

    logic [2:0] funct3;

    assign funct3 = inst[14:12];

    always_comb begin
        wmask       = '0;
        load_size   = 2'd0;
        load_signed = 1'b0;
        case (mem_kind)
            mem_store: begin
                case (funct3[1:0])
                    2'd0:    wmask = MASK_W'(8'h01); // sb
                    2'd1:    wmask = MASK_W'(8'h03); // sh
                    2'd2:    wmask = MASK_W'(8'h0f); // sw
                    default: wmask = MASK_W'(8'hff); // sd
                endcase
            end
            mem_load: begin
                load_size   = funct3[1:0];
                load_signed = !funct3[2];   // lbu, lhu, lwu
            end
            default: wmask = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/rvdec_pkg.sv
`default_nettype none

package rvdec_pkg;

    parameter int XLEN       = 64; // data and immediate width
    parameter int INST_W     = 32;
    parameter int REG_ADDR_W = 5;
    parameter int CSR_ADDR_W = 12;
    parameter int MASK_W     = 8;  // one bit per store byte

    typedef enum logic [6:0] {
        opc_op        = 7'b0110011,
        opc_op_imm    = 7'b0010011,
        opc_op_32     = 7'b0111011,
        opc_op_imm_32 = 7'b0011011,
        opc_load      = 7'b0000011,
        opc_store     = 7'b0100011,
        opc_jal       = 7'b1101111,
        opc_jalr      = 7'b1100111,
        opc_lui       = 7'b0110111,
        opc_auipc     = 7'b0010111,
        opc_branch    = 7'b1100011,
        opc_system    = 7'b1110011
    } opcode_e;

    typedef enum logic [4:0] {
        alu_add   = 5'd0,
        alu_sub   = 5'd1,
        alu_and   = 5'd2,
        alu_or    = 5'd3,
        alu_xor   = 5'd4,
        alu_sll   = 5'd5,
        alu_srl   = 5'd6,
        alu_sra   = 5'd7,
        alu_slt   = 5'd8,
        alu_sltu  = 5'd9,
        alu_mul   = 5'd10,
        alu_div   = 5'd11,
        alu_divu  = 5'd12,
        alu_rem   = 5'd13,
        alu_remu  = 5'd14,
        alu_beq   = 5'd15, // branch compares
        alu_bne   = 5'd16,
        alu_blt   = 5'd17,
        alu_bge   = 5'd18,
        alu_bltu  = 5'd19,
        alu_bgeu  = 5'd20,
        alu_csrrw = 5'd21
    } alu_op_e;

    typedef enum logic [2:0] {
        src_reg      = 3'd0, // rs1 op rs2
        src_imm      = 3'd1, // rs1 op imm
        src_pc_plus4 = 3'd2, // link value
        src_imm_pc   = 3'd3, // pc + imm
        src_csr      = 3'd4
    } alu_src_e;

    typedef enum logic [2:0] {
        imm_none  = 3'd0,
        imm_i     = 3'd1,
        imm_s     = 3'd2,
        imm_b     = 3'd3,
        imm_u     = 3'd4,
        imm_j     = 3'd5,
        imm_shamt = 3'd6
    } imm_kind_e;

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_kind_e;

    typedef enum logic [1:0] {
        sys_none   = 2'd0,
        sys_ecall  = 2'd1,
        sys_mret   = 2'd2,
        sys_ebreak = 2'd3
    } sys_kind_e;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_wen;
        alu_op_e               alu_op;
        alu_src_e              alu_src;
        logic                  word_op; // 32-bit result, sign-extended
        logic                  is_mul;
        logic                  is_div;
        logic                  branch;
        logic                  jump;
        logic                  jalr;
        logic [CSR_ADDR_W-1:0] csr_addr;
        logic                  illegal;
    } dec_ctrl_t;

    typedef struct packed {
        dec_ctrl_t         ctrl;
        logic [XLEN-1:0]   imm;
        logic [MASK_W-1:0] wmask;
        logic [1:0]        load_size;   // 0 byte .. 3 double
        logic              load_signed;
        logic              redirect;
        logic [XLEN-1:0]   redirect_pc;
        logic [XLEN-1:0]   pc;          // pc of the decoded instruction
    } dec_out_t;

endpackage

`default_nettype wire

//--- source/rvdec_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module rvdec_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid; // single-cycle pulse
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_data <= '0;
        end else if (in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- source/rvdec_top.sv
`timescale 1ns/1ps
`default_nettype none

module rvdec_top #(
    parameter int XLEN_P = rvdec_pkg::XLEN
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         in_valid,
    input  logic [rvdec_pkg::INST_W-1:0] inst,
    input  logic [XLEN_P-1:0]            pc,
    input  logic [XLEN_P-1:0]            mepc,
    input  logic [XLEN_P-1:0]            mtvec,
    output logic                         out_valid,
    output rvdec_pkg::dec_out_t          dec,
    output logic                         halted
);
    import rvdec_pkg::*;

    dec_ctrl_t         ctrl;
    imm_kind_e         imm_kind;
    mem_kind_e         mem_kind;
    sys_kind_e         sys_kind;
    logic [XLEN_P-1:0] imm;
    logic [MASK_W-1:0] wmask;
    logic [1:0]        load_size;
    logic              load_signed;
    logic              redirect;
    logic [XLEN_P-1:0] redirect_pc;
    dec_out_t          dec_d;

    rvdec_ctrl rvdec_ctrl_inst (
        .inst     (inst),
        .ctrl     (ctrl),
        .imm_kind (imm_kind),
        .mem_kind (mem_kind),
        .sys_kind (sys_kind)
    );

    rvdec_imm_gen #(.XLEN_P(XLEN_P)) rvdec_imm_gen_inst (
        .inst     (inst),
        .imm_kind (imm_kind),
        .imm      (imm)
    );

    rvdec_mem_lane rvdec_mem_lane_inst (
        .inst        (inst),
        .mem_kind    (mem_kind),
        .wmask       (wmask),
        .load_size   (load_size),
        .load_signed (load_signed)
    );

    rvdec_trap_unit #(.XLEN_P(XLEN_P)) rvdec_trap_unit_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .valid       (in_valid),
        .sys_kind    (sys_kind),
        .mepc        (mepc),
        .mtvec       (mtvec),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .halted      (halted)
    );

    assign dec_d = '{
        ctrl:        ctrl,
        imm:         imm,
        wmask:       wmask,
        load_size:   load_size,
        load_signed: load_signed,
        redirect:    redirect,
        redirect_pc: redirect_pc,
        pc:          pc
    };

    rvdec_stage_reg #(.payload_t(dec_out_t)) rvdec_stage_reg_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_data   (dec_d),
        .out_valid (out_valid),
        .out_data  (dec)
    );

endmodule

`default_nettype wire

//--- source/rvdec_trap_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rvdec_trap_unit #(
    parameter int XLEN_P = rvdec_pkg::XLEN
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 valid,
    input  rvdec_pkg::sys_kind_e sys_kind,
    input  logic [XLEN_P-1:0]    mepc,
    input  logic [XLEN_P-1:0]    mtvec,
    output logic                 redirect,
    output logic [XLEN_P-1:0]    redirect_pc,
    output logic                 halted
);
    import rvdec_pkg::*;

    always_comb begin
        redirect    = 1'b0;
        redirect_pc = '0;
        case (sys_kind)
            sys_ecall: begin
                redirect    = 1'b1;
                redirect_pc = mtvec; // trap entry
            end
            sys_mret: begin
                redirect    = 1'b1;
                redirect_pc = mepc;  // return from trap
            end
            default: redirect = 1'b0;
        endcase
    end

    // sticky until reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted <= 1'b0;
        end else if (valid && sys_kind == sys_ebreak) begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verification/rvdec_input.txt
// inst pc mepc mtvec | rs1 rs2 rd flags alu_op alu_src imm csr wmask {signed,size} redirect_pc halted
// flags = {redirect,reg_wen,word_op,is_mul,is_div,branch,jump,jalr,illegal}
002081b3 100 1000 2000 1 2 3 80 0 0 0 0 0 0 0 0
407302b3 104 1000 2000 6 7 5 80 1 0 0 0 0 0 0 0
00c5b533 108 1000 2000 b c a 80 9 0 0 0 0 0 0 0
43f4d413 10c 1000 2000 9 0 8 80 7 1 3f 0 0 0 0 0
003100bb 110 1000 2000 2 3 1 c0 0 0 0 0 0 0 0 0
41f2d21b 114 1000 2000 5 0 4 c0 7 1 1f 0 0 0 0 0
029403b3 118 1000 2000 8 9 7 a0 a 0 0 0 0 0 0 0
023150b3 11c 1000 2000 2 3 1 90 c 0 0 0 0 0 0 0
0241e13b 120 1000 2000 3 4 2 d0 d 0 0 0 0 0 0 0
fff00093 124 1000 2000 0 0 1 80 0 1 ffffffffffffffff 0 0 0 0 0
800002b7 128 1000 2000 0 0 5 80 0 1 ffffffff80000000 0 0 0 0 0
12345317 12c 1000 2000 0 0 6 80 0 3 12345000 0 0 0 0 0
ffc10083 130 1000 2000 2 0 1 80 0 1 fffffffffffffffc 0 0 4 0 0
00221183 134 1000 2000 4 0 3 80 0 1 2 0 0 5 0 0
00832283 138 1000 2000 6 0 5 80 0 1 8 0 0 6 0 0
01043383 13c 1000 2000 8 0 7 80 0 1 10 0 0 7 0 0
00014083 140 1000 2000 2 0 1 80 0 1 0 0 0 0 0 0
00015083 144 1000 2000 2 0 1 80 0 1 0 0 0 1 0 0
00016083 148 1000 2000 2 0 1 80 0 1 0 0 0 2 0 0
fe530fa3 14c 1000 2000 6 5 0 0 0 1 ffffffffffffffff 0 1 0 0 0
00531223 150 1000 2000 6 5 0 0 0 1 4 0 3 0 0 0
00532423 154 1000 2000 6 5 0 0 0 1 8 0 f 0 0 0
02533423 158 1000 2000 6 5 0 0 0 1 28 0 ff 0 0 0
fe208ce3 15c 1000 2000 1 2 0 8 f 0 fffffffffffffff8 0 0 0 0 0
0041f863 160 1000 2000 3 4 0 8 14 0 10 0 0 0 0 0
001000ef 164 1000 2000 0 0 1 84 0 2 800 0 0 0 0 0
ff0280e7 168 1000 2000 5 0 1 86 0 2 fffffffffffffff0 0 0 0 0 0
00000073 16c 1000 8000 0 0 0 100 0 0 0 0 0 0 8000 0
30200073 170 4444 2000 0 0 0 100 0 0 0 0 0 0 4444 0
305110f3 174 1000 2000 2 0 1 80 15 4 0 305 0 0 0 0
402091b3 178 1000 2000 0 0 0 1 0 0 0 0 0 0 0 0
0000007f 17c 1000 2000 0 0 0 1 0 0 0 0 0 0 0 0
00100073 180 1000 2000 0 0 0 0 0 0 0 0 0 0 0 1
002081b3 184 1000 2000 1 2 3 80 0 0 0 0 0 0 0 1

//--- verification/rvdec_sva.sv
`timescale 1ns/1ps
`default_nettype none

module rvdec_sva (
    input logic                clk,
    input logic                arst_n,
    input logic                in_valid,
    input logic                out_valid,
    input logic                halted,
    input rvdec_pkg::dec_out_t dec
);

    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid))
        else $error("out_valid does not follow in_valid by one cycle");

    a_halt_sticky: assert property (@(posedge clk) disable iff (!arst_n) !$fell(halted))
        else $error("halted fell without reset");

    a_wen_branch: assert property (@(posedge clk) disable iff (!arst_n)
        !(dec.ctrl.reg_wen && dec.ctrl.branch))
        else $error("reg_wen and branch both set");

endmodule

bind rvdec_top rvdec_sva rvdec_sva_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .halted    (halted),
    .dec       (dec)
);

`default_nettype wire

//--- verification/rvdec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rvdec_tb;
    import rvdec_pkg::*;

    localparam int NF      = 16; // words per vector in the data file
    localparam int NV      = 34;
    localparam int TIMEOUT = 20;

    logic              clk;
    logic              arst_n;
    logic              in_valid;
    logic [INST_W-1:0] inst;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   mepc;
    logic [XLEN-1:0]   mtvec;
    logic              out_valid;
    dec_out_t          dec;
    logic              halted;

    logic [63:0] vec_mem [0:NF*NV-1];
    integer      seed = 32'h814b;
    int          test_errors;
    int          passed = 0;
    int          failed = 0;

    rvdec_top #(.XLEN_P(XLEN)) rvdec_top_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .inst      (inst),
        .pc        (pc),
        .mepc      (mepc),
        .mtvec     (mtvec),
        .out_valid (out_valid),
        .dec       (dec),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic drive_vector(input int n);
        inst     = vec_mem[n*NF][31:0];
        pc       = vec_mem[n*NF+1];
        mepc     = vec_mem[n*NF+2];
        mtvec    = vec_mem[n*NF+3];
        in_valid = 1'b1;
    endtask

    task automatic wait_out_valid(input int n, output int waited);
        waited = 0;
        while (!out_valid && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!out_valid) begin
            $display("Timeout: out_valid never rose for vector %0d", n);
        end
    endtask

    task automatic check_vector(input int n);
        int         b;
        logic [8:0] flags;
        b     = n * NF;
        flags = {dec.redirect, dec.ctrl.reg_wen, dec.ctrl.word_op, dec.ctrl.is_mul,
                 dec.ctrl.is_div, dec.ctrl.branch, dec.ctrl.jump, dec.ctrl.jalr,
                 dec.ctrl.illegal};
        check_field("pc", dec.pc, vec_mem[b+1]);
        check_field("rs1", 64'(dec.ctrl.rs1), vec_mem[b+4]);
        check_field("rs2", 64'(dec.ctrl.rs2), vec_mem[b+5]);
        check_field("rd", 64'(dec.ctrl.rd), vec_mem[b+6]);
        check_field("flags", 64'(flags), vec_mem[b+7]);
        check_field("alu_op", 64'(dec.ctrl.alu_op), vec_mem[b+8]);
        check_field("alu_src", 64'(dec.ctrl.alu_src), vec_mem[b+9]);
        check_field("imm", dec.imm, vec_mem[b+10]);
        check_field("csr_addr", 64'(dec.ctrl.csr_addr), vec_mem[b+11]);
        check_field("wmask", 64'(dec.wmask), vec_mem[b+12]);
        check_field("load", 64'({dec.load_signed, dec.load_size}), vec_mem[b+13]);
        check_field("redirect_pc", dec.redirect_pc, vec_mem[b+14]);
        check_field("halted", 64'(halted), vec_mem[b+15]);
        if (test_errors == 0) begin
            passed++;
            $display("test %0d inst %h passed", n, vec_mem[b][31:0]);
        end else begin
            failed++;
            $display("test %0d inst %h failed, %0d wrong fields", n, vec_mem[b][31:0],
                     test_errors);
        end
    endtask

    initial begin
        int   gap;
        int   late;
        logic timed_out;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        inst      = '0;
        pc        = '0;
        mepc      = '0;
        mtvec     = '0;
        timed_out = 1'b0;
        $readmemh("verification/rvdec_input.txt", vec_mem);
        repeat (4) @(posedge clk);
        #1;
        assert (out_valid === 1'b0 && halted === 1'b0 && dec === '0) else begin
            $display("Outputs were not cleared by reset at %0t ns", $time);
            failed++;
        end
        arst_n = 1'b1;
        gap    = 1;
        for (int n = 0; n < NV && !timed_out; n++) begin
            test_errors = 0;
            if (gap > 0) begin
                in_valid = 1'b0;
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                    check_field("idle out_valid", 64'(out_valid), 64'd0);
                end
            end
            drive_vector(n);
            @(posedge clk);
            #1;
            wait_out_valid(n, late);
            if (!out_valid) begin
                timed_out = 1'b1;
                failed++;
            end else begin
                check_field("out_valid delay", 64'(late), 64'd0); // one cycle exactly
                check_vector(n);
                gap = $unsigned($random(seed)) % 3; // 0 keeps vectors back to back
            end
        end
        in_valid = 1'b0;
        @(posedge clk);
        #1;
        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
